// ==== Makefile ====
TOP = tb_tsn_nic

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== hdl/link_status.sv ====
module link_status import nic_pkg::*; #(
	parameter int N_PORTS       = 4,     // lanes feeding this block
	parameter int PHY_RST_DELAY = 32     // cycles from all-linked to release
) (
	input  logic               FPGA_SYS_CLK,      // 125mhz
	input  logic               FPGA_SYS_RST_N,    // sync, active low
	input  logic [N_PORTS-1:0] i_link_up,         // lane link flags
	output logic [N_PORTS-1:0] o_led,             // registered link leds
	output logic               o_phy_rst_n,       // external phy reset
	output board_state_e       o_board_state      // for debug leds
);

localparam int               CNT_W = $clog2(PHY_RST_DELAY + 1);
localparam logic [CNT_W-1:0] LAST  = CNT_W'(PHY_RST_DELAY - 1);   // last wait cycle

logic             all_up;       // every port linked
logic [CNT_W-1:0] cnt;          // phy reset delay
logic             release_nx;   // phy reset high after this edge

assign all_up     = &i_link_up;
assign release_nx = o_phy_rst_n || (all_up && (cnt == LAST));

//****************************************
// leds
//****************************************
always_ff @(posedge FPGA_SYS_CLK) begin
	if (!FPGA_SYS_RST_N) begin
		o_led <= '0;
	end else begin
		o_led <= i_link_up;              // one cycle behind the lanes
	end
end

//****************************************
// phy reset sequencing
//****************************************
always_ff @(posedge FPGA_SYS_CLK) begin
	if (!FPGA_SYS_RST_N) begin
		cnt         <= '0;
		o_phy_rst_n <= 1'b0;
	end else begin
		if (!all_up || o_phy_rst_n) begin
			cnt <= '0;                   // restart on any drop
		end else begin
			cnt <= cnt + 1'b1;
		end
		o_phy_rst_n <= release_nx;       // sticky until reset
	end
end

// board state follows the same edge as the phy reset
always_ff @(posedge FPGA_SYS_CLK) begin
	if (!FPGA_SYS_RST_N) begin
		o_board_state <= BS_RESET;
	end else if (release_nx) begin
		o_board_state <= BS_RUNNING;
	end else if (all_up) begin
		o_board_state <= BS_LINKED;      // delay counter running
	end else begin
		o_board_state <= BS_CONFIG;      // lanes still training
	end
end

endmodule

// ==== hdl/nic_pkg.sv ====
package nic_pkg;

//****************************************
// pcs register map
//****************************************
localparam int REG_ADDR_W = 5;                                   // pcs reg address bits
localparam int REG_DATA_W = 16;                                  // pcs reg word

localparam logic [REG_ADDR_W-1:0] PCS_CONTROL = 5'd0;            // control reg
localparam logic [REG_ADDR_W-1:0] PCS_STATUS  = 5'd1;            // status reg
localparam logic [REG_ADDR_W-1:0] PCS_IF_MODE = 5'd20;           // if_mode reg

localparam logic [REG_DATA_W-1:0] SGMII_IF_MODE_VAL = 16'h0003;  // bit0 sgmii_ena, bit1 sgmii an

//****************************************
// register word layouts
//****************************************
typedef struct packed {
	logic       reset;        // bit 15, self clearing
	logic       loopback;     // bit 14
	logic       rsvd_13;
	logic       an_enable;    // bit 12
	logic [1:0] rsvd_11_10;
	logic       restart_an;   // bit 9
	logic [8:0] rsvd_8_0;
} pcs_ctrl_t;

typedef struct packed {
	logic [9:0] rsvd_15_6;
	logic       an_complete;  // bit 5
	logic [1:0] rsvd_4_3;
	logic       link_status;  // bit 2
	logic [1:0] rsvd_1_0;
} pcs_status_t;

// same word, control view on writes and status view on reads
typedef union packed {
	pcs_ctrl_t   ctrl;
	pcs_status_t status;
} pcs_reg_u;

//****************************************
// bus and stream beats
//****************************************
typedef struct packed {
	logic                  cyc;   // bus cycle
	logic                  stb;   // strobe
	logic                  we;    // 1 write, 0 read
	logic [REG_ADDR_W-1:0] adr;   // reg address
	pcs_reg_u              dat;   // write data
} wb_req_t;

typedef struct packed {
	logic     ack;                // slave done
	pcs_reg_u dat;                // read data, valid with ack
} wb_rsp_t;

typedef struct packed {
	logic       en;               // tx enable
	logic       er;               // tx error
	logic [7:0] d;                // tx byte
} gmii_t;

typedef enum logic [2:0] {
	BS_RESET   = 3'd0,
	BS_CONFIG  = 3'd1,
	BS_LINKED  = 3'd2,
	BS_RUNNING = 3'd3
} board_state_e;

endpackage

// ==== hdl/reset_holdoff.sv ====
module reset_holdoff #(
	parameter int HOLDOFF_CYCLES = 16          // wait after reset release
) (
	input  logic FPGA_SYS_CLK,                 // 125mhz
	input  logic FPGA_SYS_RST_N,               // sync, active low
	output logic o_start                       // single pulse to the lanes
);

localparam int              CNT_W = $clog2(HOLDOFF_CYCLES + 2);
localparam logic [CNT_W-1:0] LAST = CNT_W'(HOLDOFF_CYCLES + 1);   // pulse point

logic [CNT_W-1:0] cnt;    // cycles since release
logic             done;   // pulse already issued

// stands in for pll lock, counts once per reset
always_ff @(posedge FPGA_SYS_CLK) begin
	if (!FPGA_SYS_RST_N) begin
		cnt     <= '0;
		done    <= 1'b0;
		o_start <= 1'b0;
	end else begin
		if (cnt != LAST) begin
			cnt <= cnt + 1'b1;             // saturates at LAST
		end
		o_start <= (cnt == LAST) && !done; // one cycle only
		if (cnt == LAST) begin
			done <= 1'b1;                  // quiet until next reset
		end
	end
end

endmodule

// ==== hdl/sgmii_port.sv ====
module sgmii_port import nic_pkg::*; (
	input  logic    FPGA_SYS_CLK,     // 125mhz
	input  logic    FPGA_SYS_RST_N,   // sync, active low
	input  logic    i_start,          // hold-off pulse
	// pcs register port
	output wb_req_t o_pcs_wb,         // wishbone classic master
	input  wb_rsp_t i_pcs_wb,
	// gmii transmit
	input  gmii_t   i_gmii_tx,        // from switch core
	output gmii_t   o_gmii_tx,        // to pcs
	output logic    o_link_up         // link and an both good
);

//****************************************
// configuration fsm
//****************************************
typedef enum logic [1:0] {
	S_IDLE    = 2'd0,   // wait for start
	S_WR_MODE = 2'd1,   // write if_mode
	S_WR_CTRL = 2'd2,   // enable + restart an
	S_RD_STAT = 2'd3    // poll status
} lane_state_e;

lane_state_e state;
pcs_status_t rd_stat;    // read word seen as status
logic        bus_done;   // ack on an open cycle

assign rd_stat  = i_pcs_wb.dat.status;
assign bus_done = o_pcs_wb.cyc && i_pcs_wb.ack;

// request word for each access state
function automatic wb_req_t build_req(input lane_state_e s);
	wb_req_t   r;
	pcs_ctrl_t ctrl;
	r               = '0;
	ctrl            = '0;
	ctrl.an_enable  = 1'b1;
	ctrl.restart_an = 1'b1;    // self clearing in the pcs
	r.cyc           = 1'b1;
	r.stb           = 1'b1;
	case (s)
		S_WR_MODE: begin
			r.we  = 1'b1;
			r.adr = PCS_IF_MODE;
			r.dat = SGMII_IF_MODE_VAL;   // raw word, not a control layout
		end
		S_WR_CTRL: begin
			r.we       = 1'b1;
			r.adr      = PCS_CONTROL;
			r.dat.ctrl = ctrl;
		end
		default: begin
			r.we  = 1'b0;                // status read, dat unused
			r.adr = PCS_STATUS;
		end
	endcase
	return r;
endfunction

always_ff @(posedge FPGA_SYS_CLK) begin
	if (!FPGA_SYS_RST_N) begin
		state     <= S_IDLE;
		o_pcs_wb  <= '0;
		o_link_up <= 1'b0;
	end else if (state == S_IDLE) begin
		if (i_start) begin
			state    <= S_WR_MODE;
			o_pcs_wb <= build_req(S_WR_MODE);   // first request next cycle
		end
	end else if (bus_done) begin
		o_pcs_wb.cyc <= 1'b0;                   // one idle cycle between accesses
		o_pcs_wb.stb <= 1'b0;
		case (state)
			S_WR_MODE: begin
				state <= S_WR_CTRL;
			end
			S_WR_CTRL: begin
				state <= S_RD_STAT;
			end
			S_RD_STAT: begin
				if (!rd_stat.link_status) begin
					o_link_up <= 1'b0;
					if (o_link_up) begin
						state <= S_WR_CTRL;     // link lost, restart an
					end
				end else if (rd_stat.an_complete) begin
					o_link_up <= 1'b1;          // link + an done
				end
			end
			default: begin
				state <= S_IDLE;
			end
		endcase
	end else if (!o_pcs_wb.cyc) begin
		o_pcs_wb <= build_req(state);           // open next access
	end
end

//****************************************
// gmii transmit gate
//****************************************
// core stream passes only on a live link, idle line otherwise
always_ff @(posedge FPGA_SYS_CLK) begin
	if (!FPGA_SYS_RST_N) begin
		o_gmii_tx <= '0;
	end else if (o_link_up) begin
		o_gmii_tx <= i_gmii_tx;                 // one cycle delay
	end else begin
		o_gmii_tx <= '0;                        // en/er low, data zero
	end
end

endmodule

// ==== hdl/tsn_nic_top.sv ====
module tsn_nic_top import nic_pkg::*; #(
	parameter int N_PORTS        = 4,    // sgmii ports on the card
	parameter int HOLDOFF_CYCLES = 16,   // start-up wait after reset
	parameter int PHY_RST_DELAY  = 32    // all-linked to phy reset release
) (
	input  logic                FPGA_SYS_CLK,             // 125mhz
	input  logic                FPGA_SYS_RST_N,           // sync, active low
	// switch core transmit side
	input  gmii_t               i_gmii_tx [N_PORTS],      // core gmii per port
	output gmii_t               o_gmii_tx [N_PORTS],      // gated gmii to pcs
	// pcs register blocks
	output wb_req_t             o_pcs_wb  [N_PORTS],      // one wishbone master per port
	input  wb_rsp_t             i_pcs_wb  [N_PORTS],
	// board
	output logic                o_phy_rst_n,              // external phy reset
	output logic [N_PORTS-1:0]  o_led,                    // per port link leds
	output logic [4:0]          o_debug_led               // state + device id
);

localparam logic [1:0] DEVICE_ID = 2'b01;   // fixed board id pattern

logic               start;         // hold-off pulse to lanes
logic [N_PORTS-1:0] link_up;       // lane link flags
board_state_e       board_state;

//****************************************
// start-up hold-off
//****************************************
reset_holdoff #(
	.HOLDOFF_CYCLES (HOLDOFF_CYCLES)
) u_holdoff (
	.FPGA_SYS_CLK   (FPGA_SYS_CLK),
	.FPGA_SYS_RST_N (FPGA_SYS_RST_N),
	.o_start        (start)
);

//****************************************
// port lanes
//****************************************
for (genvar g = 0; g < N_PORTS; g++) begin : g_port
	sgmii_port u_port (
		.FPGA_SYS_CLK   (FPGA_SYS_CLK),
		.FPGA_SYS_RST_N (FPGA_SYS_RST_N),
		.i_start        (start),
		.o_pcs_wb       (o_pcs_wb[g]),    // to pcs reg block g
		.i_pcs_wb       (i_pcs_wb[g]),
		.i_gmii_tx      (i_gmii_tx[g]),   // core stream
		.o_gmii_tx      (o_gmii_tx[g]),
		.o_link_up      (link_up[g])
	);
end

//****************************************
// status, leds and phy reset
//****************************************
link_status #(
	.N_PORTS       (N_PORTS),
	.PHY_RST_DELAY (PHY_RST_DELAY)
) u_status (
	.FPGA_SYS_CLK   (FPGA_SYS_CLK),
	.FPGA_SYS_RST_N (FPGA_SYS_RST_N),
	.i_link_up      (link_up),
	.o_led          (o_led),
	.o_phy_rst_n    (o_phy_rst_n),
	.o_board_state  (board_state)
);

// debug leds: state on top, id on bottom
assign o_debug_led = {board_state, DEVICE_ID};

endmodule

// ==== list.f ====
hdl/nic_pkg.sv
hdl/reset_holdoff.sv
hdl/sgmii_port.sv
hdl/link_status.sv
hdl/tsn_nic_top.sv
verification/tsn_nic_asserts.sv
verification/tb_tsn_nic.sv

// ==== verification/tb_tsn_nic.sv ====
module tb_tsn_nic import nic_pkg::*; ();
timeunit 1ns;
timeprecision 100ps;

localparam int N_PORTS        = 4;
localparam int HOLDOFF_CYCLES = 16;
localparam int PHY_RST_DELAY  = 32;
localparam logic [15:0] CTRL_EXP = 16'h1200;   // an_enable bit 12, restart_an bit 9

logic               FPGA_SYS_CLK;
logic               FPGA_SYS_RST_N;
gmii_t              gmii_in   [N_PORTS];
gmii_t              gmii_out  [N_PORTS];
wb_req_t            pcs_req   [N_PORTS];
wb_rsp_t            pcs_rsp   [N_PORTS] = '{default: '0};
logic               phy_rst_n;
logic [N_PORTS-1:0] led;
logic [4:0]         debug_led;

logic [N_PORTS-1:0] link_flag;                      // pcs model status bits
logic [N_PORTS-1:0] an_flag;
logic               ack_rand;                       // random ack stalls on
logic [2:0]         ack_delay [N_PORTS] = '{default: '0};
logic [2:0]         ack_wait  [N_PORTS] = '{default: '0};
logic [21:0]        acc_log   [N_PORTS][$];         // {we, adr, dat} per access
logic [31:0]        lfsr;
int                 n_checks;
int                 n_errors;

tsn_nic_top #(
	.N_PORTS        (N_PORTS),
	.HOLDOFF_CYCLES (HOLDOFF_CYCLES),
	.PHY_RST_DELAY  (PHY_RST_DELAY)
) DUT (
	.FPGA_SYS_CLK   (FPGA_SYS_CLK),
	.FPGA_SYS_RST_N (FPGA_SYS_RST_N),
	.i_gmii_tx      (gmii_in),
	.o_gmii_tx      (gmii_out),
	.o_pcs_wb       (pcs_req),
	.i_pcs_wb       (pcs_rsp),
	.o_phy_rst_n    (phy_rst_n),
	.o_led          (led),
	.o_debug_led    (debug_led)
);

bind sgmii_port tsn_nic_asserts u_lane_chk (
	.FPGA_SYS_CLK (FPGA_SYS_CLK), .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
	.i_wb_req (o_pcs_wb), .i_wb_rsp (i_pcs_wb), .i_phy_rst_n (1'b1)
);
bind link_status tsn_nic_asserts u_status_chk (
	.FPGA_SYS_CLK (FPGA_SYS_CLK), .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
	.i_wb_req ('0), .i_wb_rsp ('0), .i_phy_rst_n (o_phy_rst_n)
);

initial begin
	FPGA_SYS_CLK = 1'b0;
	forever #10 FPGA_SYS_CLK = ~FPGA_SYS_CLK;       // 20 ns period
end

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v    = {v[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
	end
	return v;
endfunction

function automatic pcs_reg_u status_word(input int p);
	pcs_reg_u w;
	w                    = '0;
	w.status.link_status = link_flag[p];
	w.status.an_complete = an_flag[p];
	return w;
endfunction

//****************************************
// pcs register block models
//****************************************
always @(posedge FPGA_SYS_CLK) begin
	logic [31:0] r;
	for (int p = 0; p < N_PORTS; p++) begin
		if (!FPGA_SYS_RST_N) begin
			pcs_rsp[p]   <= '0;
			ack_wait[p]  <= '0;
			ack_delay[p] <= '0;
		end else if (pcs_rsp[p].ack) begin
			pcs_rsp[p].ack <= 1'b0;                 // single cycle ack
		end else if (pcs_req[p].cyc && pcs_req[p].stb) begin
			if (ack_wait[p] >= ack_delay[p]) begin
				pcs_rsp[p].ack <= 1'b1;
				pcs_rsp[p].dat <= status_word(p);   // ignored on writes
				acc_log[p].push_back({pcs_req[p].we, pcs_req[p].adr, pcs_req[p].dat});
				ack_wait[p] <= '0;
				if (ack_rand) begin
					r            = rand_bits(3);
					ack_delay[p] <= r[2:0];
				end
			end else begin
				ack_wait[p] <= ack_wait[p] + 3'd1;  // stall
			end
		end
	end
end

//****************************************
// checks and waits
//****************************************
task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
	end
endtask

task automatic report_problem(input string msg);
	n_errors++;
	$display("ERROR t=%0t %s", $time, msg);
endtask

task automatic wait_led(input int p, input logic v);
	int n;
	n = 0;
	while (led[p] !== v && n < 600) begin
		@(negedge FPGA_SYS_CLK);
		n++;
	end
	if (led[p] !== v)
		report_problem($sformatf("o_led[%0d] never went to %0b", p, v));
endtask

task automatic wait_log_len(input int p, input int len);
	int n;
	n = 0;
	while (acc_log[p].size() < len && n < 1000) begin
		@(negedge FPGA_SYS_CLK);
		n++;
	end
	if (acc_log[p].size() < len)
		report_problem($sformatf("pcs %0d saw only %0d accesses", p, acc_log[p].size()));
endtask

task automatic apply_reset();
	@(posedge FPGA_SYS_CLK);
	FPGA_SYS_RST_N <= 1'b0;
	@(negedge FPGA_SYS_CLK);
	for (int p = 0; p < N_PORTS; p++) begin
		acc_log[p].delete();                        // model is quiet from here
	end
	repeat (4) @(posedge FPGA_SYS_CLK);
	FPGA_SYS_RST_N <= 1'b1;
endtask

task automatic expect_quiet();
	for (int p = 0; p < N_PORTS; p++) begin
		compare_value($sformatf("o_pcs_wb[%0d].cyc", p), 32'(pcs_req[p].cyc), 32'(0));
		compare_value($sformatf("o_pcs_wb[%0d].stb", p), 32'(pcs_req[p].stb), 32'(0));
		compare_value($sformatf("o_gmii_tx[%0d].en", p), 32'(gmii_out[p].en), 32'(0));
		compare_value($sformatf("o_gmii_tx[%0d].er", p), 32'(gmii_out[p].er), 32'(0));
	end
	compare_value("o_phy_rst_n", 32'(phy_rst_n), 32'(0));
	compare_value("o_led", 32'(led), 32'(0));
	compare_value("o_debug_led[1:0]", 32'(debug_led[1:0]), 32'(2'b01));
endtask

task automatic verify_config_log(input int p);
	if (acc_log[p].size() < 3) begin
		report_problem($sformatf("pcs %0d log too short for the config order", p));
	end else begin
		compare_value($sformatf("pcs%0d access 0", p), 32'(acc_log[p][0]),
			32'({1'b1, PCS_IF_MODE, SGMII_IF_MODE_VAL}));
		compare_value($sformatf("pcs%0d access 1", p), 32'(acc_log[p][1]),
			32'({1'b1, PCS_CONTROL, CTRL_EXP}));
		for (int i = 2; i < acc_log[p].size(); i++) begin
			compare_value($sformatf("pcs%0d access %0d we/adr", p, i),
				32'(acc_log[p][i][21:16]), 32'({1'b0, PCS_STATUS}));   // reads only
		end
	end
endtask

//****************************************
// directed tests
//****************************************
task automatic reset_state();
	int n;
	@(posedge FPGA_SYS_CLK);
	for (int p = 0; p < N_PORTS; p++) begin
		gmii_in[p] <= '1;                           // gate must hold en/er low
	end
	apply_reset();
	@(negedge FPGA_SYS_CLK);
	expect_quiet();
	compare_value("o_debug_led[4:2]", 32'(debug_led[4:2]), 32'(BS_RESET));
	n = 0;
	while (n < HOLDOFF_CYCLES + 10) begin
		@(negedge FPGA_SYS_CLK);                    // n counts edges after release
		expect_quiet();
		if (DUT.u_holdoff.o_start === 1'b1)
			break;
		n++;
	end
	if (DUT.u_holdoff.o_start !== 1'b1) begin
		report_problem("start pulse never came after reset release");
	end else begin
		compare_value("start pulse cycle", 32'(n), 32'(HOLDOFF_CYCLES + 1));
	end
	@(negedge FPGA_SYS_CLK);
	for (int p = 0; p < N_PORTS; p++) begin
		compare_value($sformatf("o_pcs_wb[%0d].cyc", p), 32'(pcs_req[p].cyc), 32'(1));
		compare_value($sformatf("o_pcs_wb[%0d].adr", p), 32'(pcs_req[p].adr), 32'(PCS_IF_MODE));
	end
endtask

task automatic config_order();
	for (int p = 0; p < N_PORTS; p++) begin
		wait_log_len(p, 6);
		verify_config_log(p);
	end
endtask

task automatic gmii_forwarding(input logic linked);
	gmii_t       prev [N_PORTS];
	logic [31:0] r;
	@(negedge FPGA_SYS_CLK);
	prev = gmii_in;
	repeat (40) begin
		@(posedge FPGA_SYS_CLK);
		for (int p = 0; p < N_PORTS; p++) begin
			r          = rand_bits(10);
			gmii_in[p] <= r[9:0];
		end
		@(negedge FPGA_SYS_CLK);
		for (int p = 0; p < N_PORTS; p++) begin
			compare_value($sformatf("o_gmii_tx[%0d]", p), 32'(gmii_out[p]),
				linked ? 32'(prev[p]) : 32'(0));    // one beat late, or idle
		end
		prev = gmii_in;
	end
endtask

task automatic link_bringup();
	int n;
	for (int p = 0; p < N_PORTS; p++) begin
		@(posedge FPGA_SYS_CLK);
		link_flag[p] <= 1'b1;
		an_flag[p]   <= 1'b1;
		wait_led(p, 1'b1);
		for (int q = p + 1; q < N_PORTS; q++) begin
			compare_value($sformatf("o_led[%0d]", q), 32'(led[q]), 32'(0));
		end
		if (p < N_PORTS - 1) begin
			compare_value("o_phy_rst_n", 32'(phy_rst_n), 32'(0));
			compare_value("o_debug_led[4:2]", 32'(debug_led[4:2]), 32'(BS_CONFIG));
		end
	end
	// leds trail the lane flags by one cycle, so release lands one cycle sooner
	n = 0;
	while (phy_rst_n !== 1'b1 && n < PHY_RST_DELAY + 20) begin
		compare_value("o_debug_led[4:2]", 32'(debug_led[4:2]), 32'(BS_LINKED));
		@(negedge FPGA_SYS_CLK);
		n++;
	end
	if (phy_rst_n !== 1'b1) begin
		report_problem("phy reset was never released");
	end else begin
		compare_value("phy release cycles", 32'(n), 32'(PHY_RST_DELAY - 1));
	end
	compare_value("o_debug_led[4:2]", 32'(debug_led[4:2]), 32'(BS_RUNNING));
endtask

task automatic link_loss();
	int start;
	int n;
	int idx;
	@(negedge FPGA_SYS_CLK);
	start = acc_log[2].size();
	@(posedge FPGA_SYS_CLK);
	link_flag[2] <= 1'b0;
	gmii_in[2]   <= '1;                             // busy input, idle output expected
	wait_led(2, 1'b0);
	compare_value("o_gmii_tx[2]", 32'(gmii_out[2]), 32'(0));
	compare_value("o_phy_rst_n", 32'(phy_rst_n), 32'(1));
	idx = -1;
	n   = 0;
	while (idx < 0 && n < 200) begin
		for (int i = start; i < acc_log[2].size(); i++) begin
			if (acc_log[2][i][21] && idx < 0)
				idx = i;                            // first write after the loss
		end
		if (idx < 0) begin
			@(negedge FPGA_SYS_CLK);
			n++;
		end
	end
	if (idx < 0) begin
		report_problem("port 2 never rewrote its control register");
	end else begin
		compare_value("pcs2 write after loss", 32'(acc_log[2][idx]),
			32'({1'b1, PCS_CONTROL, CTRL_EXP}));
	end
	@(posedge FPGA_SYS_CLK);
	link_flag[2] <= 1'b1;
	wait_led(2, 1'b1);
	compare_value("o_phy_rst_n", 32'(phy_rst_n), 32'(1));
endtask

task automatic ack_backpressure();
	@(negedge FPGA_SYS_CLK);
	ack_rand = 1'b1;
	apply_reset();
	for (int p = 0; p < N_PORTS; p++) begin
		wait_led(p, 1'b1);
	end
	for (int p = 0; p < N_PORTS; p++) begin
		wait_log_len(p, 10);
		verify_config_log(p);
	end
endtask

initial begin
	FPGA_SYS_RST_N = 1'b0;
	link_flag      = '0;
	an_flag        = '0;
	ack_rand       = 1'b0;
	lfsr           = 32'h220d;
	n_checks       = 0;
	n_errors       = 0;
	for (int p = 0; p < N_PORTS; p++) begin
		gmii_in[p] = '0;
	end
	reset_state();
	config_order();
	gmii_forwarding(1'b0);
	link_bringup();
	gmii_forwarding(1'b1);
	link_loss();
	ack_backpressure();
	$display("summary: %0d checks, %0d errors", n_checks, n_errors);
	if (n_errors == 0) begin
		$display("All tests passed!");
	end else begin
		$display("Test failures found");
	end
	$finish;
end

endmodule

// ==== verification/tsn_nic_asserts.sv ====
module tsn_nic_asserts import nic_pkg::*; (
	input logic    FPGA_SYS_CLK,      // 125mhz
	input logic    FPGA_SYS_RST_N,    // sync, active low
	input wb_req_t i_wb_req,          // lane request, tied off on the status block
	input wb_rsp_t i_wb_rsp,          // pcs response
	input logic    i_phy_rst_n        // phy reset, tied high on the lanes
);
timeunit 1ns;
timeprecision 100ps;

//****************************************
// wishbone classic master rules
//****************************************
a_stb_in_cyc: assert property (@(posedge FPGA_SYS_CLK) i_wb_req.stb |-> i_wb_req.cyc)
	else $error("wishbone stb high without cyc");

// request frozen while the slave stalls
a_req_stable: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
	(i_wb_req.stb && !i_wb_rsp.ack) |=> $stable(i_wb_req))
	else $error("wishbone request changed before ack");

a_cyc_drop: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
	(i_wb_req.cyc && i_wb_rsp.ack) |=> !i_wb_req.cyc)
	else $error("wishbone cyc still high after ack");   // one idle cycle expected

//****************************************
// phy reset
//****************************************
a_phy_sticky: assert property (@(posedge FPGA_SYS_CLK)
	(FPGA_SYS_RST_N && i_phy_rst_n) |=> i_phy_rst_n)
	else $error("phy reset reasserted outside system reset");

endmodule
